// ==== list.f ====
rtl/board_pkg.sv
rtl/board_cfg_if.sv
rtl/dip_config.sv
rtl/joy_4way.sv
rtl/joy_mapper.sv
rtl/front_panel_ctrl.sv
rtl/board_inputs.sv
testbench/front_panel_props.sv
testbench/tb_board_inputs.sv

// ==== rtl/board_cfg_if.sv ====
/*
  Decoded settings from the settings block to the input logic.
  All signals are registered levels on clk_sys with no handshake.
*/
interface board_cfg_if;

    // Vertical screen rotation on
    logic rot_control;
    // Screen flip, swaps the rotation direction
    logic flip;
    // Four-way joystick filtering on
    logic en4way;
    // Pause requested from the on-screen menu
    logic osd_pause;

    modport cfg_src (
        output rot_control,
        output flip,
        output en4way,
        output osd_pause
    );

    modport joy_sink (
        input rot_control,
        input flip,
        input en4way
    );

    modport panel_sink (
        input osd_pause
    );

endinterface

// ==== rtl/board_inputs.sv ====
/*
  Player input and settings path of the arcade board wrapper.
  Single clock domain, synchronous active-high reset.
  Key inputs are decoded keyboard levels on clk_sys.
  Game joystick, coin and start outputs are undefined until the first
  clock after reset.
*/
module board_inputs #(
    parameter int BUTTONS                = 2,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1
) (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic [31:0]                       status,
    input  logic [6:0]                        core_mod,
    input  logic                              downloading,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick1,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick2,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick3,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick4,
    input  logic [1:0]                        db_coin,
    input  logic [1:0]                        db_start,
    // Keyboard levels
    input  logic [board_pkg::GAME_JOY_W-1:0]  key_joy1,
    input  logic [board_pkg::GAME_JOY_W-1:0]  key_joy2,
    input  logic [board_pkg::GAME_JOY_W-1:0]  key_joy3,
    input  logic [board_pkg::PLAYERS-1:0]     key_coin,
    input  logic [board_pkg::PLAYERS-1:0]     key_start,
    input  logic                              key_test,
    input  logic                              key_pause,
    input  logic                              key_reset,
    input  logic [board_pkg::GFX_LAYERS-1:0]  key_gfx,
    input  logic                              key_service,
    // Game side
    output logic [board_pkg::GAME_JOY_W-1:0]  game_joystick1,
    output logic [board_pkg::GAME_JOY_W-1:0]  game_joystick2,
    output logic [board_pkg::GAME_JOY_W-1:0]  game_joystick3,
    output logic [board_pkg::GAME_JOY_W-1:0]  game_joystick4,
    output logic [board_pkg::PLAYERS-1:0]     game_coin,
    output logic [board_pkg::PLAYERS-1:0]     game_start,
    output logic                              game_service,
    output logic                              dip_test,
    output logic                              dip_pause,
    output logic [1:0]                        dip_fxlevel,
    output logic                              enable_fm,
    output logic                              enable_psg,
    output logic                              soft_rst,
    output logic [board_pkg::GFX_LAYERS-1:0]  gfx_en
);

    logic game_pause;
    logic joy_pause;

    board_cfg_if i_cfg ();

    dip_config i_dip_config (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .status      (status),
        .core_mod    (core_mod),
        .key_test    (key_test),
        .game_pause  (game_pause),
        .cfg         (i_cfg),
        .dip_test    (dip_test),
        .dip_pause   (dip_pause),
        .dip_fxlevel (dip_fxlevel),
        .enable_fm   (enable_fm),
        .enable_psg  (enable_psg)
    );

    joy_mapper #(
        .BUTTONS                (BUTTONS),
        .GAME_INPUTS_ACTIVE_LOW (GAME_INPUTS_ACTIVE_LOW)
    ) i_joy_mapper (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .board_joystick3 (board_joystick3),
        .board_joystick4 (board_joystick4),
        .key_joy1        (key_joy1),
        .key_joy2        (key_joy2),
        .key_joy3        (key_joy3),
        .db_coin         (db_coin),
        .db_start        (db_start),
        .key_coin        (key_coin),
        .key_start       (key_start),
        .cfg             (i_cfg),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_joystick3  (game_joystick3),
        .game_joystick4  (game_joystick4),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .joy_pause       (joy_pause)
    );

    front_panel_ctrl #(
        .GAME_INPUTS_ACTIVE_LOW (GAME_INPUTS_ACTIVE_LOW)
    ) i_front_panel_ctrl (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .downloading  (downloading),
        .key_pause    (key_pause),
        .key_reset    (key_reset),
        .key_gfx      (key_gfx),
        .key_service  (key_service),
        .joy_pause    (joy_pause),
        .cfg          (i_cfg),
        .game_pause   (game_pause),
        .soft_rst     (soft_rst),
        .gfx_en       (gfx_en),
        .game_service (game_service)
    );

endmodule

// ==== rtl/board_pkg.sv ====
/*
  Shared constants for the arcade board input path.
  Joystick words carry the four directions in the low bits, then the
  buttons, start, coin and pause at positions that depend on the
  number of game buttons.
  Status field positions follow the front-end menu layout.
*/
package board_pkg;

    // Widths and counts
    parameter int PLAYERS     = 4;
    parameter int BOARD_JOY_W = 16;
    parameter int GAME_JOY_W  = 10;
    parameter int DIR_W       = 4;
    parameter int GFX_LAYERS  = 4;

    // Direction bits inside every joystick word
    parameter int DIR_RIGHT = 0;
    parameter int DIR_LEFT  = 1;
    parameter int DIR_DOWN  = 2;
    parameter int DIR_UP    = 3;

    // Status word fields
    parameter int ST_ROTATE      = 2;
    parameter int ST_FLIP        = 3;
    // Two-bit effects level starts here
    parameter int ST_FXLEVEL_LSB = 4;
    parameter int ST_TEST        = 6;
    parameter int ST_OSD_PAUSE   = 7;
    parameter int ST_FM_OFF      = 8;
    parameter int ST_PSG_OFF     = 9;

    // Core mode bits
    parameter int CM_4WAY = 1;

endpackage

// ==== rtl/dip_config.sv ====
/*
  Settings decoder for the 32-bit status word and the core mode bits.
  Every output is registered, one cycle behind its source bit.
  After reset the game runs unpaused with both sound chips enabled.
*/
module dip_config (
    input  logic        clk_sys,
    input  logic        rst,
    input  logic [31:0] status,
    input  logic [6:0]  core_mod,
    input  logic        key_test,
    input  logic        game_pause,
    board_cfg_if.cfg_src cfg,
    output logic        dip_test,
    output logic        dip_pause,
    output logic [1:0]  dip_fxlevel,
    output logic        enable_fm,
    output logic        enable_psg
);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cfg.rot_control <= 1'b0;
            cfg.flip        <= 1'b0;
            cfg.en4way      <= 1'b0;
            cfg.osd_pause   <= 1'b0;
            dip_test        <= 1'b0;
            dip_pause       <= 1'b1;
            dip_fxlevel     <= 2'd0;
            enable_fm       <= 1'b1;
            enable_psg      <= 1'b1;
        end else begin
            // Settings seen by the joystick and front-panel logic
            cfg.rot_control <= status[board_pkg::ST_ROTATE];
            cfg.flip        <= status[board_pkg::ST_FLIP];
            cfg.en4way      <= core_mod[board_pkg::CM_4WAY];
            cfg.osd_pause   <= status[board_pkg::ST_OSD_PAUSE];

            // Test mode from the menu or from the keyboard
            dip_test    <= status[board_pkg::ST_TEST] | key_test;
            // Game side expects pause active low
            dip_pause   <= ~game_pause;
            dip_fxlevel <= status[board_pkg::ST_FXLEVEL_LSB +: 2];

            // Menu bits disable, outputs enable
            enable_fm  <= ~status[board_pkg::ST_FM_OFF];
            enable_psg <= ~status[board_pkg::ST_PSG_OFF];
        end
    end

endmodule

// ==== rtl/front_panel_ctrl.sv ====
/*
  Front-panel controls: pause toggle, soft reset pulse, graphics
  layer toggles and the service line.
  Key inputs must already be synchronous to clk_sys.
  A menu pause change overrides a key toggle in the same cycle, and
  ROM download holds the game unpaused.
*/
module front_panel_ctrl #(
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1
) (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic                             downloading,
    input  logic                             key_pause,
    input  logic                             key_reset,
    input  logic [board_pkg::GFX_LAYERS-1:0] key_gfx,
    input  logic                             key_service,
    input  logic                             joy_pause,
    board_cfg_if.panel_sink                  cfg,
    output logic                             game_pause,
    output logic                             soft_rst,
    output logic [board_pkg::GFX_LAYERS-1:0] gfx_en,
    output logic                             game_service
);

    // Previous levels for edge detection
    logic                             last_pause;
    logic                             last_joy_pause;
    logic                             last_osd_pause;
    logic                             last_reset;
    logic [board_pkg::GFX_LAYERS-1:0] last_gfx;

    logic pause_edge;
    logic osd_change;

    assign pause_edge = (key_pause & ~last_pause) | (joy_pause & ~last_joy_pause);
    assign osd_change = cfg.osd_pause ^ last_osd_pause;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_pause     <= 1'b0;
            last_joy_pause <= 1'b0;
            last_osd_pause <= 1'b0;
            last_reset     <= 1'b0;
            last_gfx       <= '0;
            game_pause     <= 1'b0;
            soft_rst       <= 1'b0;
            gfx_en         <= '1;
            game_service   <= GAME_INPUTS_ACTIVE_LOW;
        end else begin
            last_pause     <= key_pause;
            last_joy_pause <= joy_pause;
            last_osd_pause <= cfg.osd_pause;
            last_reset     <= key_reset;
            last_gfx       <= key_gfx;

            // Single cycle pulse per key press
            soft_rst <= key_reset & ~last_reset;
            gfx_en   <= gfx_en ^ (key_gfx & ~last_gfx);

            game_service <= key_service ^ GAME_INPUTS_ACTIVE_LOW;

            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_change) begin
                // Menu setting wins over a key press
                game_pause <= cfg.osd_pause;
            end else if (pause_edge) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

// ==== rtl/joy_4way.sv ====
/*
  Eight-way to four-way direction filter for one joystick.
  Output is registered, one cycle behind the input.
  When disabled the directions pass unchanged. When enabled a held
  direction is kept and a new one picks the highest pressed bit.
*/
module joy_4way (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  logic                        enable,
    input  logic [board_pkg::DIR_W-1:0] joy8way,
    output logic [board_pkg::DIR_W-1:0] joy4way
);

    // Current output direction that is still pressed
    logic [board_pkg::DIR_W-1:0] held;
    // Highest-numbered pressed direction, one-hot
    logic [board_pkg::DIR_W-1:0] top_dir;

    assign held = joy4way & joy8way;

    always_comb begin
        top_dir = '0;
        for (int i = 0; i < board_pkg::DIR_W; i++) begin
            if (joy8way[i]) begin
                top_dir    = '0;
                top_dir[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy4way <= '0;
        end else if (!enable) begin
            joy4way <= joy8way;
        end else if (|held) begin
            // Stick stays on the direction it already reports
            joy4way <= held;
        end else begin
            // Zero when nothing is pressed
            joy4way <= top_dir;
        end
    end

endmodule

// ==== rtl/joy_mapper.sv ====
/*
  Joystick path for four players.
  Buttons take two cycles to reach the game outputs, directions take
  three because they pass the four-way filter first.
  Key words are levels from the keyboard decoder and are not synchronized.
  Player four has no key word. Game outputs are undefined until the first
  clock after reset.
*/
module joy_mapper #(
    parameter int BUTTONS                = 2,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1
) (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick1,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick2,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick3,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick4,
    input  logic [board_pkg::GAME_JOY_W-1:0]  key_joy1,
    input  logic [board_pkg::GAME_JOY_W-1:0]  key_joy2,
    input  logic [board_pkg::GAME_JOY_W-1:0]  key_joy3,
    input  logic [1:0]                        db_coin,
    input  logic [1:0]                        db_start,
    input  logic [board_pkg::PLAYERS-1:0]     key_coin,
    input  logic [board_pkg::PLAYERS-1:0]     key_start,
    board_cfg_if.joy_sink                     cfg,
    output logic [board_pkg::GAME_JOY_W-1:0]  game_joystick1,
    output logic [board_pkg::GAME_JOY_W-1:0]  game_joystick2,
    output logic [board_pkg::GAME_JOY_W-1:0]  game_joystick3,
    output logic [board_pkg::GAME_JOY_W-1:0]  game_joystick4,
    output logic [board_pkg::PLAYERS-1:0]     game_coin,
    output logic [board_pkg::PLAYERS-1:0]     game_start,
    output logic                              joy_pause
);

    // Start, coin and pause sit right above the game buttons
    localparam int START_BIT = 6 + BUTTONS - 2;
    localparam int COIN_BIT  = START_BIT + 1;
    localparam int PAUSE_BIT = COIN_BIT + 1;

    logic [board_pkg::BOARD_JOY_W-1:0] board_joy [board_pkg::PLAYERS];
    logic [board_pkg::GAME_JOY_W-1:0]  key_joy   [board_pkg::PLAYERS];
    logic [board_pkg::DIR_W-1:0]       joy_dir   [board_pkg::PLAYERS];
    logic [board_pkg::BOARD_JOY_W-1:0] joy_sync  [board_pkg::PLAYERS];
    logic [board_pkg::GAME_JOY_W-1:0]  game_joy  [board_pkg::PLAYERS];
    logic [board_pkg::PLAYERS-1:0]     sync_coin;
    logic [board_pkg::PLAYERS-1:0]     sync_start;

    // Directions swapped for vertical screens
    function automatic logic [board_pkg::GAME_JOY_W-1:0] apply_rotation(
        input logic [board_pkg::GAME_JOY_W-1:0] joy_in,
        input logic                             rot,
        input logic                             flip
    );
        logic [board_pkg::GAME_JOY_W-1:0] joy_out;
        joy_out = joy_in;
        if (rot && flip) begin
            joy_out[board_pkg::DIR_UP]    = joy_in[board_pkg::DIR_RIGHT];
            joy_out[board_pkg::DIR_DOWN]  = joy_in[board_pkg::DIR_LEFT];
            joy_out[board_pkg::DIR_LEFT]  = joy_in[board_pkg::DIR_UP];
            joy_out[board_pkg::DIR_RIGHT] = joy_in[board_pkg::DIR_DOWN];
        end else if (rot) begin
            joy_out[board_pkg::DIR_UP]    = joy_in[board_pkg::DIR_LEFT];
            joy_out[board_pkg::DIR_DOWN]  = joy_in[board_pkg::DIR_RIGHT];
            joy_out[board_pkg::DIR_LEFT]  = joy_in[board_pkg::DIR_DOWN];
            joy_out[board_pkg::DIR_RIGHT] = joy_in[board_pkg::DIR_UP];
        end
        return joy_out;
    endfunction

    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;
    assign key_joy[0]   = key_joy1;
    assign key_joy[1]   = key_joy2;
    assign key_joy[2]   = key_joy3;
    assign key_joy[3]   = '0;

    for (genvar g = 0; g < board_pkg::PLAYERS; g++) begin : g_player
        joy_4way i_joy_4way (
            .clk_sys (clk_sys),
            .rst     (rst),
            .enable  (cfg.en4way),
            .joy8way (board_joy[g][board_pkg::DIR_W-1:0]),
            .joy4way (joy_dir[g])
        );

        // Buttons synchronized here, directions come from the filter register
        always_ff @(posedge clk_sys) begin
            joy_sync[g] <= {board_joy[g][board_pkg::BOARD_JOY_W-1:board_pkg::DIR_W], joy_dir[g]};
            game_joy[g] <= {board_pkg::GAME_JOY_W{GAME_INPUTS_ACTIVE_LOW}} ^
                apply_rotation(joy_sync[g][board_pkg::GAME_JOY_W-1:0] | key_joy[g],
                               cfg.rot_control, cfg.flip);
        end

        assign sync_coin[g]  = joy_sync[g][COIN_BIT];
        assign sync_start[g] = joy_sync[g][START_BIT];
    end

    // Debounced cabinet buttons exist for players one and two only
    always_ff @(posedge clk_sys) begin
        game_coin  <= {board_pkg::PLAYERS{GAME_INPUTS_ACTIVE_LOW}} ^
            (sync_coin | key_coin | {{(board_pkg::PLAYERS - 2){1'b0}}, db_coin});
        game_start <= {board_pkg::PLAYERS{GAME_INPUTS_ACTIVE_LOW}} ^
            (sync_start | key_start | {{(board_pkg::PLAYERS - 2){1'b0}}, db_start});
    end

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];
    assign game_joystick3 = game_joy[2];
    assign game_joystick4 = game_joy[3];

    assign joy_pause = joy_sync[0][PAUSE_BIT] | joy_sync[1][PAUSE_BIT];

endmodule

// ==== testbench/front_panel_props.sv ====
/*
  Assertions on the front-panel control, bound into front_panel_ctrl.
  The pulse and download checks are off while rst is high.
*/
module front_panel_props (
    input logic                             clk_sys,
    input logic                             rst,
    input logic                             downloading,
    input logic                             soft_rst,
    input logic                             game_pause,
    input logic [board_pkg::GFX_LAYERS-1:0] gfx_en
);

    // One pulse per reset key press
    soft_rst_single: assert property (
        @(posedge clk_sys) disable iff (rst) soft_rst |=> !soft_rst
    ) else $error("soft_rst stayed high for two cycles");

    // All layers visible out of reset
    gfx_reset_on: assert property (
        @(posedge clk_sys) rst |=> (gfx_en == '1)
    ) else $error("gfx_en not all ones after reset");

    download_unpause: assert property (
        @(posedge clk_sys) disable iff (rst) downloading |=> !game_pause
    ) else $error("game_pause high after downloading");

endmodule

bind front_panel_ctrl front_panel_props i_front_panel_props (
    .clk_sys     (clk_sys),
    .rst         (rst),
    .downloading (downloading),
    .soft_rst    (soft_rst),
    .game_pause  (game_pause),
    .gfx_en      (gfx_en)
);

// ==== testbench/tb_board_inputs.sv ====
/*
  Testbench for board_inputs with default parameters, so game inputs
  are active low. Player one, the debounced buttons, key_pause,
  key_test, key_service, the status word, core mode and downloading
  change during the table run. The reset and layer keys are pressed
  once at the end. Tests share DUT state, so the table order matters.
*/
module tb_board_inputs;

    localparam int HOLD_CYCLES = 6;
    localparam int WAIT_LIMIT  = 20;

    logic        clk_sys;
    logic        rst;
    logic [31:0] status;
    logic [6:0]  core_mod;
    logic        downloading;
    logic [15:0] board_joystick1, board_joystick2, board_joystick3, board_joystick4;
    logic [1:0]  db_coin, db_start;
    logic [9:0]  key_joy1, key_joy2, key_joy3;
    logic [3:0]  key_coin, key_start, key_gfx;
    logic        key_test, key_pause, key_reset, key_service;
    logic [9:0]  game_joystick1, game_joystick2, game_joystick3, game_joystick4;
    logic [3:0]  game_coin, game_start, gfx_en;
    logic        game_service, dip_test, dip_pause, enable_fm, enable_psg, soft_rst;
    logic [1:0]  dip_fxlevel;

    // Test table, one entry per test
    string       name_q[$];
    logic [60:0] stim_q[$];
    logic [18:0] expect_q[$];

    integer seed;
    int     errors;
    int     failed_tests;
    int     tests;

    board_inputs i_board_inputs (.*);

    always #4 clk_sys = ~clk_sys;

    task automatic add_test(input string name, input logic [60:0] stim,
                            input logic [18:0] expected);
        name_q.push_back(name);
        stim_q.push_back(stim);
        expect_q.push_back(expected);
    endtask

    // Stimulus: joystick 1, {db_coin, db_start}, key_pause, status, core_mod, downloading
    // Expected: game_joystick1, {game_coin, game_start}, dip_pause
    task automatic build_table();
        add_test("rest", {16'h0000, 4'h0, 1'b0, 32'h00, 7'h0, 1'b0}, {10'h3FF, 8'hFF, 1'b1});
        add_test("right", {16'h0001, 4'h0, 1'b0, 32'h00, 7'h0, 1'b0}, {10'h3FE, 8'hFF, 1'b1});
        add_test("left", {16'h0002, 4'h0, 1'b0, 32'h00, 7'h0, 1'b0}, {10'h3FD, 8'hFF, 1'b1});
        add_test("down", {16'h0004, 4'h0, 1'b0, 32'h00, 7'h0, 1'b0}, {10'h3FB, 8'hFF, 1'b1});
        add_test("up", {16'h0008, 4'h0, 1'b0, 32'h00, 7'h0, 1'b0}, {10'h3F7, 8'hFF, 1'b1});
        add_test("button 1", {16'h0010, 4'h0, 1'b0, 32'h00, 7'h0, 1'b0}, {10'h3EF, 8'hFF, 1'b1});
        // Rotation, up takes left and down takes right
        add_test("rot left", {16'h0002, 4'h0, 1'b0, 32'h04, 7'h0, 1'b0}, {10'h3F7, 8'hFF, 1'b1});
        add_test("rot right", {16'h0001, 4'h0, 1'b0, 32'h04, 7'h0, 1'b0}, {10'h3FB, 8'hFF, 1'b1});
        add_test("rot down", {16'h0004, 4'h0, 1'b0, 32'h04, 7'h0, 1'b0}, {10'h3FD, 8'hFF, 1'b1});
        add_test("rot up", {16'h0008, 4'h0, 1'b0, 32'h04, 7'h0, 1'b0}, {10'h3FE, 8'hFF, 1'b1});
        // Flipped, up takes right and down takes left
        add_test("flip right", {16'h0001, 4'h0, 1'b0, 32'h0C, 7'h0, 1'b0}, {10'h3F7, 8'hFF, 1'b1});
        add_test("flip left", {16'h0002, 4'h0, 1'b0, 32'h0C, 7'h0, 1'b0}, {10'h3FB, 8'hFF, 1'b1});
        add_test("flip up", {16'h0008, 4'h0, 1'b0, 32'h0C, 7'h0, 1'b0}, {10'h3FD, 8'hFF, 1'b1});
        add_test("flip down", {16'h0004, 4'h0, 1'b0, 32'h0C, 7'h0, 1'b0}, {10'h3FE, 8'hFF, 1'b1});
        // Four-way filter keeps the held direction
        add_test("4way up", {16'h0008, 4'h0, 1'b0, 32'h00, 7'h2, 1'b0}, {10'h3F7, 8'hFF, 1'b1});
        add_test("4way up+rt", {16'h0009, 4'h0, 1'b0, 32'h00, 7'h2, 1'b0}, {10'h3F7, 8'hFF, 1'b1});
        add_test("4way right", {16'h0001, 4'h0, 1'b0, 32'h00, 7'h2, 1'b0}, {10'h3FE, 8'hFF, 1'b1});
        add_test("4way rest", {16'h0000, 4'h0, 1'b0, 32'h00, 7'h2, 1'b0}, {10'h3FF, 8'hFF, 1'b1});
        add_test("4way dn+lt", {16'h0006, 4'h0, 1'b0, 32'h00, 7'h2, 1'b0}, {10'h3FB, 8'hFF, 1'b1});
        // Debounced cabinet buttons, with the sound and effects fields moving too
        add_test("db coin 1", {16'h0000, 4'h4, 1'b0, 32'h150, 7'h0, 1'b0}, {10'h3FF, 8'hEF, 1'b1});
        add_test("db coin 2", {16'h0000, 4'h8, 1'b0, 32'h260, 7'h0, 1'b0}, {10'h3FF, 8'hDF, 1'b1});
        add_test("db start 1", {16'h0000, 4'h1, 1'b0, 32'h30, 7'h0, 1'b0}, {10'h3FF, 8'hFE, 1'b1});
        add_test("db start 2", {16'h0000, 4'h2, 1'b0, 32'h00, 7'h0, 1'b0}, {10'h3FF, 8'hFD, 1'b1});
        // Pause toggles, menu override and download clear
        add_test("pause key", {16'h0000, 4'h0, 1'b1, 32'h00, 7'h0, 1'b0}, {10'h3FF, 8'hFF, 1'b0});
        add_test("pause up", {16'h0000, 4'h0, 1'b0, 32'h00, 7'h0, 1'b0}, {10'h3FF, 8'hFF, 1'b0});
        add_test("pause again", {16'h0000, 4'h0, 1'b1, 32'h00, 7'h0, 1'b0}, {10'h3FF, 8'hFF, 1'b1});
        add_test("menu pause", {16'h0000, 4'h0, 1'b0, 32'h80, 7'h0, 1'b0}, {10'h3FF, 8'hFF, 1'b0});
        add_test("download", {16'h0000, 4'h0, 1'b0, 32'h80, 7'h0, 1'b1}, {10'h3FF, 8'hFF, 1'b1});
        add_test("dl done", {16'h0000, 4'h0, 1'b0, 32'h80, 7'h0, 1'b0}, {10'h3FF, 8'hFF, 1'b1});
        add_test("joy pause", {16'h0100, 4'h0, 1'b0, 32'h80, 7'h0, 1'b0}, {10'h2FF, 8'hFF, 1'b0});
        add_test("menu off", {16'h0000, 4'h0, 1'b0, 32'h00, 7'h0, 1'b0}, {10'h3FF, 8'hFF, 1'b1});
    endtask

    task automatic apply_entry(input int idx);
        logic [15:0] joy;
        logic [31:0] filler;
        filler = $random(seed);
        @(posedge clk_sys);
        #1;
        {joy, db_coin, db_start, key_pause, status, core_mod, downloading} = stim_q[idx];
        // Bits above the game word are ignored by the DUT
        board_joystick1 = {filler[15:10], joy[9:0]};
        // Keyboard test and service keys follow the filler as well
        key_service = filler[16];
        key_test    = filler[17];
    endtask

    task automatic wait_dip_pause(input logic level, output bit timed_out);
        int cycles;
        cycles = 0;
        timed_out = 1'b0;
        while (dip_pause !== level && !timed_out) begin
            @(negedge clk_sys);
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic report_test(input string name, input int test_errors);
        tests++;
        if (test_errors == 0) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s with %0d bad values", name, test_errors);
            failed_tests++;
        end
        errors += test_errors;
    endtask

    // Reset key gives one pulse, layer keys 0 and 2 hide their layers
    task automatic check_panel_keys(output int bad);
        int cycles;
        bad = 0;
        cycles = 0;
        @(posedge clk_sys);
        #1;
        key_reset = 1'b1;
        key_gfx   = 4'b0101;
        @(negedge clk_sys);
        while (soft_rst !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (soft_rst !== 1'b1) begin
            $display("Test panel keys: soft_rst did not pulse within %0d cycles", WAIT_LIMIT);
            bad++;
        end
        @(negedge clk_sys);
        if (soft_rst !== 1'b0) begin
            $display("MISMATCH panel keys soft_rst expected 0 actual %b", soft_rst);
            bad++;
        end
        if (gfx_en !== 4'b1010) begin
            $display("MISMATCH panel keys gfx_en expected %h actual %h", 4'b1010, gfx_en);
            bad++;
        end
    endtask

    initial begin : run
        logic [9:0] x_joy;
        logic [3:0] x_coin;
        logic [3:0] x_start;
        logic       x_dip;
        logic [4:0] x_set;
        logic       x_service;
        bit         timed_out;
        int         test_errors;
        seed = 22;
        errors = 0;
        failed_tests = 0;
        tests = 0;
        clk_sys = 1'b0;
        rst = 1'b1;
        status = '0;
        core_mod = '0;
        downloading = 1'b0;
        {board_joystick1, board_joystick2, board_joystick3, board_joystick4} = '0;
        {db_coin, db_start, key_coin, key_start, key_gfx} = '0;
        {key_joy1, key_joy2, key_joy3} = '0;
        {key_test, key_pause, key_reset, key_service} = '0;
        build_table();
        repeat (4) @(posedge clk_sys);
        #1;
        rst = 1'b0;
        for (int i = 0; i < name_q.size(); i++) begin
            apply_entry(i);
            repeat (HOLD_CYCLES) @(posedge clk_sys);
            // Sample away from the clock edge
            @(negedge clk_sys);
            {x_joy, x_coin, x_start, x_dip} = expect_q[i];
            // Status bits 6, 5:4, 8 and 9 hold test, effects level, FM off and PSG off
            x_set = {status[6] | key_test, status[5:4], ~status[8], ~status[9]};
            // Service line is active low on the game side
            x_service = ~key_service;
            test_errors = 0;
            wait_dip_pause(x_dip, timed_out);
            if (timed_out) begin
                $display("Test %s: dip_pause did not reach %b within %0d cycles",
                         name_q[i], x_dip, WAIT_LIMIT);
                test_errors++;
            end
            if (game_joystick1 !== x_joy) begin
                $display("MISMATCH %s game_joystick1 expected %h actual %h",
                         name_q[i], x_joy, game_joystick1);
                test_errors++;
            end
            if (game_coin !== x_coin) begin
                $display("MISMATCH %s game_coin expected %h actual %h",
                         name_q[i], x_coin, game_coin);
                test_errors++;
            end
            if (game_start !== x_start) begin
                $display("MISMATCH %s game_start expected %h actual %h",
                         name_q[i], x_start, game_start);
                test_errors++;
            end
            if ({game_joystick2, game_joystick3, game_joystick4} !== {3{10'h3FF}}) begin
                $display("MISMATCH %s game_joystick2-4 expected %h actual %h",
                         name_q[i], {3{10'h3FF}},
                         {game_joystick2, game_joystick3, game_joystick4});
                test_errors++;
            end
            if ({dip_test, dip_fxlevel, enable_fm, enable_psg} !== x_set) begin
                $display("MISMATCH %s dip settings expected %b actual %b",
                         name_q[i], x_set, {dip_test, dip_fxlevel, enable_fm, enable_psg});
                test_errors++;
            end
            if (game_service !== x_service) begin
                $display("MISMATCH %s game_service expected %b actual %b",
                         name_q[i], x_service, game_service);
                test_errors++;
            end
            report_test(name_q[i], test_errors);
        end
        check_panel_keys(test_errors);
        report_test("panel keys", test_errors);
        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
